//--- src.f
src/uart_pkg.sv
src/uart_rx.sv
src/uart_tx.sv
src/uart_fifo.sv
src/uart_top.sv
test/tb_clock.sv
test/tb_uart.sv

//--- run_sim.sh
#!/bin/sh
# Build the UART testbench with Verilator, run it and check the log.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing \
   --top-module tb_uart \
   -f src.f \
   -o sim_uart

./obj_dir/sim_uart | tee sim.log

if grep -q "^STATUS: PASS$" sim.log; then
   echo "simulation passed"
   exit 0
else
   echo "simulation failed"
   exit 1
fi

//--- test/tb_uart.sv
// UART peripheral testbench.
// Walks a table of receive, loopback and glitch frames and checks
// the FIFO output, error pulses and transmit frame shape.

`default_nettype none

module tb_uart;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int CLKS_PER_BIT = 8;
   localparam int FIFO_DEPTH   = 4;
   localparam int NUM_ROWS     = 13;

   typedef enum logic [1:0] {MODE_RX, MODE_LOOP, MODE_GLITCH} mode_e;

   typedef struct packed {
      uart_pkg::byte_t data;
      mode_e           mode;
      logic            stop;
      logic            accept;
   } row_t;

   // loopback rows take their byte from the lfsr.
   row_t rows [NUM_ROWS] = '{
      '{8'h55, MODE_RX, 1'b1, 1'b0},
      '{8'hC3, MODE_RX, 1'b1, 1'b1},
      '{8'h3C, MODE_RX, 1'b0, 1'b1},  // framing error.
      '{8'h00, MODE_GLITCH, 1'b1, 1'b1},
      '{8'h81, MODE_RX, 1'b1, 1'b1},
      '{8'h11, MODE_RX, 1'b1, 1'b0},
      '{8'h22, MODE_RX, 1'b1, 1'b0},
      '{8'h44, MODE_RX, 1'b1, 1'b0},
      '{8'h88, MODE_RX, 1'b1, 1'b0},
      '{8'hF0, MODE_RX, 1'b1, 1'b1},  // dropped as the fifo is full.
      '{8'h00, MODE_LOOP, 1'b1, 1'b1},
      '{8'h00, MODE_LOOP, 1'b1, 1'b1},
      '{8'h00, MODE_LOOP, 1'b1, 1'b1}
   };

   wire             clk;
   wire             nrst;
   wire             rx_line;
   logic            rx_bang;
   logic            loop_q;
   logic            loopback;
   logic            rx_accept;
   uart_pkg::byte_t tx_data;
   logic            tx_start;
   uart_pkg::byte_t rx_data;
   logic            rx_valid;
   logic            rx_overrun;
   logic            frame_err;
   logic            tx_out;
   logic            tx_busy;

   uart_pkg::byte_t model [$];
   logic [31:0]     lfsr_state;
   int              n_ferr = 0;
   int              n_ovr = 0;
   int              exp_ferr = 0;
   int              exp_ovr = 0;

   tb_clock i_tb_clock (
      .o_clk  (clk),
      .o_nrst (nrst)
   );

   uart_top #(
      .CLKS_PER_BIT (CLKS_PER_BIT),
      .FIFO_DEPTH   (FIFO_DEPTH)
   ) i_uart_top (
      .i_clk        (clk),
      .i_nrst       (nrst),
      .i_rx         (rx_line),
      .i_rx_accept  (rx_accept),
      .i_tx_data    (tx_data),
      .i_tx_start   (tx_start),
      .o_rx_data    (rx_data),
      .o_rx_valid   (rx_valid),
      .o_rx_overrun (rx_overrun),
      .o_frame_err  (frame_err),
      .o_tx         (tx_out),
      .o_tx_busy    (tx_busy)
   );

   assign rx_line = loopback ? loop_q : rx_bang;

   always @(posedge clk) begin
      #2;
      loop_q = tx_out;  // serial output fed back once per clock.
   end

   // pulse counters sample mid-cycle.
   always @(negedge clk) begin
      if (nrst) begin
         if (frame_err) n_ferr++;
         if (rx_overrun) n_ovr++;
      end
   end

   task automatic stop_with_error(input string msg);
      $display("%s", msg);
      $display("STATUS: FAIL");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_byte(input string name, input uart_pkg::byte_t got,
                             input uart_pkg::byte_t want);
      if (got !== want)
         stop_with_error($sformatf("FAIL %s got 0x%h expected 0x%h", name, got, want));
   endtask

   task automatic check_bit(input string name, input logic got, input logic want);
      if (got !== want)
         stop_with_error($sformatf("FAIL %s got 0x%h expected 0x%h", name, got, want));
   endtask

   task automatic check_count(input string name, input int got, input int want);
      if (got != want)
         stop_with_error($sformatf("FAIL %s got 0x%h expected 0x%h", name, got, want));
   endtask

   task automatic step();
      @(posedge clk);
      #2;
   endtask

   function automatic logic [31:0] galois_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
   endfunction

   task automatic random_byte(output uart_pkg::byte_t b);
      b = '0;
      for (int i = 0; i < 8; i++) begin
         lfsr_state = galois_step(lfsr_state);
         b[i] = lfsr_state[0];
      end
   endtask

   // 8N1 line level for bit k of a frame.
   function automatic logic frame_bit(input uart_pkg::byte_t d, input int k);
      if (k == 0) return 1'b0;
      if (k == 9) return 1'b1;
      return d[k-1];
   endfunction

   task automatic drive_bit(input logic b);
      rx_bang = b;
      repeat (CLKS_PER_BIT) step();
   endtask

   task automatic send_line_frame(input uart_pkg::byte_t d, input logic stop_bit);
      drive_bit(1'b0);
      for (int i = 0; i < 8; i++) drive_bit(d[i]);
      drive_bit(stop_bit);
      rx_bang = 1'b1;
   endtask

   task automatic send_glitch();
      rx_bang = 1'b0;
      repeat (CLKS_PER_BIT / 2 - 1) step();
      rx_bang = 1'b1;
   endtask

   task automatic send_tx_frame(input uart_pkg::byte_t d);
      int cycles;
      check_bit("o_tx_busy", tx_busy, 1'b0);
      tx_data  = d;
      tx_start = 1'b1;
      step();
      tx_start = 1'b0;
      check_bit("o_tx_busy", tx_busy, 1'b1);
      cycles = 0;
      while (tx_busy) begin
         if (cycles % CLKS_PER_BIT == CLKS_PER_BIT / 2)
            check_bit("o_tx", tx_out, frame_bit(d, cycles / CLKS_PER_BIT));
         // a strobe while busy must be ignored.
         tx_start = (cycles == 2 * CLKS_PER_BIT);
         tx_data  = ~d;
         step();
         cycles++;
         if (cycles > 12 * CLKS_PER_BIT)
            stop_with_error("timeout waiting for o_tx_busy to fall");
      end
      tx_start = 1'b0;
      check_count("o_tx_busy high clocks", cycles, 10 * CLKS_PER_BIT);
   endtask

   task automatic wait_valid();
      int waited;
      waited = 0;
      while (!rx_valid) begin
         step();
         waited++;
         if (waited > 12 * CLKS_PER_BIT)
            stop_with_error("timeout waiting for o_rx_valid to rise");
      end
   endtask

   task automatic wait_events();
      int waited;
      waited = 0;
      while (n_ferr < exp_ferr || n_ovr < exp_ovr) begin
         step();
         waited++;
         if (waited > 12 * CLKS_PER_BIT)
            stop_with_error("timeout waiting for a frame error or overrun pulse");
      end
   endtask

   // models one finished frame as an error, a drop or a store.
   task automatic expect_outcome(input uart_pkg::byte_t d, input logic stop_bit);
      if (!stop_bit) begin
         exp_ferr++;
         wait_events();
      end else if (model.size() == FIFO_DEPTH) begin
         exp_ovr++;
         wait_events();
      end else begin
         model.push_back(d);
         wait_valid();
      end
   endtask

   task automatic drain_fifo();
      uart_pkg::byte_t want;
      while (model.size() > 0) begin
         want = model.pop_front();
         check_bit("o_rx_valid", rx_valid, 1'b1);
         check_byte("o_rx_data", rx_data, want);
         rx_accept = 1'b1;
         step();
         rx_accept = 1'b0;
      end
      check_bit("o_rx_valid", rx_valid, 1'b0);
      rx_accept = 1'b1;  // accept on empty.
      step();
      rx_accept = 1'b0;
      check_bit("o_rx_valid", rx_valid, 1'b0);
   endtask

   initial begin
      uart_pkg::byte_t data;
      int              waited;
      rx_bang    = 1'b1;
      loopback   = 1'b0;
      rx_accept  = 1'b0;
      tx_data    = '0;
      tx_start   = 1'b0;
      lfsr_state = 32'ha255_ccbe;
      waited     = 0;
      while (!nrst) begin
         step();
         waited++;
         if (waited > 20) stop_with_error("reset was never released");
      end
      check_bit("o_tx", tx_out, 1'b1);
      check_bit("o_tx_busy", tx_busy, 1'b0);
      check_bit("o_rx_valid", rx_valid, 1'b0);
      check_bit("o_rx_overrun", rx_overrun, 1'b0);
      check_bit("o_frame_err", frame_err, 1'b0);

      for (int r = 0; r < NUM_ROWS; r++) begin
         data = rows[r].data;
         case (rows[r].mode)
            MODE_RX: begin
               send_line_frame(data, rows[r].stop);
               expect_outcome(data, rows[r].stop);
            end
            MODE_LOOP: begin
               random_byte(data);
               loopback = 1'b1;
               send_tx_frame(data);
               expect_outcome(data, 1'b1);
               loopback = 1'b0;
            end
            default: send_glitch();
         endcase
         repeat (CLKS_PER_BIT) step();  // idle gap between frames.
         check_count("o_frame_err pulses", n_ferr, exp_ferr);
         check_count("o_rx_overrun pulses", n_ovr, exp_ovr);
         if (rows[r].accept) drain_fifo();
      end

      $display("STATUS: PASS");
      $finish;
   end

endmodule

`default_nettype wire

//--- test/tb_clock.sv
// Testbench clock and reset source.
// 20 ns clock; active low reset held for eight cycles.

`default_nettype none

module tb_clock (
   output logic o_clk,
   output logic o_nrst
);
   timeunit 1ns;
   timeprecision 1ps;

   initial begin
      o_clk = 1'b0;
      forever #10 o_clk = ~o_clk;
   end

   initial begin
      o_nrst = 1'b0;
      repeat (8) @(posedge o_clk);
      @(negedge o_clk);
      o_nrst = 1'b1;  // released away from the rising edge.
   end

endmodule

`default_nettype wire

//--- src/uart_top.sv
// UART peripheral top level.
// Receiver feeding a receive FIFO, plus an independent transmitter.

`default_nettype none

module uart_top #(
   parameter int CLKS_PER_BIT = 16,
   parameter int FIFO_DEPTH   = 4
) (
   input  wire                i_clk,
   input  wire                i_nrst,
   input  wire                i_rx,
   input  wire                i_rx_accept,
   input  uart_pkg::byte_t    i_tx_data,
   input  wire                i_tx_start,
   output uart_pkg::byte_t    o_rx_data,
   output logic               o_rx_valid,
   output logic               o_rx_overrun,
   output logic               o_frame_err,
   output logic               o_tx,
   output logic               o_tx_busy
);

   uart_pkg::byte_t rx_byte;
   logic            rx_byte_valid;

   uart_rx #(
      .CLKS_PER_BIT (CLKS_PER_BIT)
   ) i_uart_rx (
      .i_clk        (i_clk),
      .i_nrst       (i_nrst),
      .i_rx         (i_rx),
      .o_data       (rx_byte),
      .o_valid      (rx_byte_valid),
      .o_frame_err  (o_frame_err)
   );

   // the fifo pops only while it shows valid data.
   uart_fifo #(
      .FIFO_DEPTH   (FIFO_DEPTH)
   ) i_uart_fifo (
      .i_clk        (i_clk),
      .i_nrst       (i_nrst),
      .i_wr_data    (rx_byte),
      .i_wr         (rx_byte_valid),
      .i_rd         (i_rx_accept),
      .o_rd_data    (o_rx_data),
      .o_not_empty  (o_rx_valid),
      .o_overrun    (o_rx_overrun)
   );

   uart_tx #(
      .CLKS_PER_BIT (CLKS_PER_BIT)
   ) i_uart_tx (
      .i_clk        (i_clk),
      .i_nrst       (i_nrst),
      .i_tx_data    (i_tx_data),
      .i_tx_start   (i_tx_start),
      .o_tx         (o_tx),
      .o_tx_busy    (o_tx_busy)
   );

endmodule

`default_nettype wire

//--- src/uart_fifo.sv
// UART receive FIFO.
// Circular register buffer with extra-bit pointers; a write while
// full is dropped and flagged as an overrun.

`default_nettype none

module uart_fifo #(
   parameter int FIFO_DEPTH = 4
) (
   input  wire                i_clk,
   input  wire                i_nrst,
   input  uart_pkg::byte_t    i_wr_data,
   input  wire                i_wr,
   input  wire                i_rd,
   output uart_pkg::byte_t    o_rd_data,
   output logic               o_not_empty,
   output logic               o_overrun
);

   localparam int ADDR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [ADDR_W:0]   ptr_t;

   uart_pkg::byte_t mem [FIFO_DEPTH];
   ptr_t            wr_ptr;
   ptr_t            rd_ptr;
   logic            full;
   logic            empty;
   logic            do_wr;
   logic            do_rd;

   // same address, different wrap bit.
   assign full  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                  (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);
   assign empty = (wr_ptr == rd_ptr);

   assign do_wr = i_wr && !full;
   assign do_rd = i_rd && !empty;

   assign o_not_empty = !empty;
   assign o_rd_data   = mem[addr_t'(rd_ptr[ADDR_W-1:0])];

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         o_overrun <= 1'b0;
      end else begin
         o_overrun <= i_wr && full;
         if (do_wr) begin
            wr_ptr <= wr_ptr + ptr_t'(1);
         end
         if (do_rd) begin
            rd_ptr <= rd_ptr + ptr_t'(1);
         end
      end
   end

   always_ff @(posedge i_clk) begin
      if (do_wr) begin
         mem[addr_t'(wr_ptr[ADDR_W-1:0])] <= i_wr_data;
      end
   end

endmodule

`default_nettype wire

//--- src/uart_tx.sv
// UART transmitter, 8N1 at a fixed baud rate.
// Sends one frame per accepted start strobe and holds busy for
// the full ten bit times.

`default_nettype none

module uart_tx #(
   parameter int CLKS_PER_BIT = 16
) (
   input  wire                i_clk,
   input  wire                i_nrst,
   input  uart_pkg::byte_t    i_tx_data,
   input  wire                i_tx_start,
   output logic               o_tx,
   output logic               o_tx_busy
);

   localparam int CNT_W = (CLKS_PER_BIT > 2) ? $clog2(CLKS_PER_BIT) : 1;

   typedef logic [CNT_W-1:0] cnt_t;

   localparam cnt_t FULL = cnt_t'(CLKS_PER_BIT - 1);

   uart_pkg::tx_state_e state;
   cnt_t                count;
   logic [2:0]          bit_idx;
   uart_pkg::byte_t     shreg;
   logic                accept;
   logic                bit_end;

   assign accept  = (state == uart_pkg::TX_IDLE) && i_tx_start;
   assign bit_end = (count == FULL);

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state     <= uart_pkg::TX_IDLE;
         count     <= '0;
         bit_idx   <= '0;
         o_tx      <= 1'b1;
         o_tx_busy <= 1'b0;
      end else begin
         if (state != uart_pkg::TX_IDLE) begin
            count <= bit_end ? '0 : count + cnt_t'(1);
         end
         case (state)
            uart_pkg::TX_IDLE: begin
               count <= '0;
               if (accept) begin
                  o_tx      <= 1'b0;  // start bit.
                  o_tx_busy <= 1'b1;
                  bit_idx   <= '0;
                  state     <= uart_pkg::TX_START;
               end
            end
            uart_pkg::TX_START: begin
               if (bit_end) begin
                  o_tx  <= shreg[0];
                  state <= uart_pkg::TX_DATA;
               end
            end
            uart_pkg::TX_DATA: begin
               if (bit_end) begin
                  bit_idx <= bit_idx + 3'd1;
                  if (bit_idx == 3'd7) begin
                     o_tx  <= 1'b1;  // stop bit.
                     state <= uart_pkg::TX_STOP;
                  end else begin
                     o_tx <= shreg[0];
                  end
               end
            end
            uart_pkg::TX_STOP: begin
               if (bit_end) begin
                  o_tx_busy <= 1'b0;
                  state     <= uart_pkg::TX_IDLE;
               end
            end
            default: state <= uart_pkg::TX_IDLE;
         endcase
      end
   end

   // shifts once per bit so shreg[0] is always the next bit out.
   always_ff @(posedge i_clk) begin
      if (accept) begin
         shreg <= i_tx_data;
      end else if (bit_end && (state == uart_pkg::TX_START || state == uart_pkg::TX_DATA)) begin
         shreg <= {1'b1, shreg[7:1]};
      end
   end

endmodule

`default_nettype wire

//--- src/uart_rx.sv
// UART receiver, 8N1 at a fixed baud rate.
// Oversamples the synchronized line with a clock counter, rejects
// false starts at half a bit time and checks the stop bit.

`default_nettype none

module uart_rx #(
   parameter int CLKS_PER_BIT = 16
) (
   input  wire                i_clk,
   input  wire                i_nrst,
   input  wire                i_rx,
   output uart_pkg::byte_t    o_data,
   output logic               o_valid,
   output logic               o_frame_err
);

   localparam int CNT_W = (CLKS_PER_BIT > 2) ? $clog2(CLKS_PER_BIT) : 1;

   typedef logic [CNT_W-1:0] cnt_t;

   localparam cnt_t FULL = cnt_t'(CLKS_PER_BIT - 1);
   localparam cnt_t HALF = cnt_t'(CLKS_PER_BIT / 2 - 1);

   uart_pkg::rx_state_e state;
   cnt_t                count;
   logic [2:0]          bit_idx;
   logic                rx_meta;
   logic                rx_sync;
   logic                shift_en;

   // two-flop synchronizer, idles high.
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         rx_meta <= 1'b1;
         rx_sync <= 1'b1;
      end else begin
         rx_meta <= i_rx;
         rx_sync <= rx_meta;
      end
   end

   assign shift_en = (state == uart_pkg::RX_DATA) && (count == FULL);

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state       <= uart_pkg::RX_IDLE;
         count       <= '0;
         bit_idx     <= '0;
         o_valid     <= 1'b0;
         o_frame_err <= 1'b0;
      end else begin
         o_valid     <= 1'b0;
         o_frame_err <= 1'b0;
         if (state != uart_pkg::RX_IDLE) begin
            count <= count + cnt_t'(1);
         end
         case (state)
            uart_pkg::RX_IDLE: begin
               count <= '0;
               if (!rx_sync) begin
                  state <= uart_pkg::RX_START;
               end
            end
            uart_pkg::RX_START: begin
               if (count == HALF) begin
                  count   <= '0;
                  bit_idx <= '0;
                  // line back high means a glitch, not a start bit.
                  state   <= rx_sync ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
               end
            end
            uart_pkg::RX_DATA: begin
               if (count == FULL) begin
                  count   <= '0;
                  bit_idx <= bit_idx + 3'd1;
                  if (bit_idx == 3'd7) begin
                     state <= uart_pkg::RX_STOP;
                  end
               end
            end
            uart_pkg::RX_STOP: begin
               if (count == FULL) begin
                  count       <= '0;
                  o_valid     <= rx_sync;
                  o_frame_err <= !rx_sync;  // stop bit low.
                  state       <= uart_pkg::RX_IDLE;
               end
            end
            default: state <= uart_pkg::RX_IDLE;
         endcase
      end
   end

   // lsb first, so new bits enter at the top.
   always_ff @(posedge i_clk) begin
      if (shift_en) begin
         o_data <= {rx_sync, o_data[7:1]};
      end
   end

endmodule

`default_nettype wire

//--- src/uart_pkg.sv
// UART shared definitions.
// Byte type for the serial data path and the state encodings of
// the receiver and transmitter state machines.

`default_nettype none

package uart_pkg;

   // one data byte on the line, in the fifo and at the ports.
   typedef logic [7:0] byte_t;

   // receiver states.
   typedef enum logic [1:0] {
      RX_IDLE  = 2'd0,  // waiting for a falling edge.
      RX_START = 2'd1,  // timing to the middle of the start bit.
      RX_DATA  = 2'd2,  // sampling the eight data bits.
      RX_STOP  = 2'd3   // sampling the stop bit.
   } rx_state_e;

   // transmitter states.
   typedef enum logic [1:0] {
      TX_IDLE  = 2'd0,
      TX_START = 2'd1,
      TX_DATA  = 2'd2,
      TX_STOP  = 2'd3
   } tx_state_e;

endpackage

`default_nettype wire
